/* include/hart_params.svh */
`ifndef HART_PARAMS_SVH
`define HART_PARAMS_SVH

// hart count and hart index width
`define HART_NUM     4
`define HART_ID_W    2

// register byte offsets
`define REG_CTRL     4'h0
`define REG_STATUS   4'h4
`define REG_SWITCHES 4'h8

// CTRL register fields
`define CTRL_START_BIT 8
`define CTRL_KILL_BIT  9

// STATUS register field offsets
`define STAT_IDLE_LSB 0
`define STAT_ACTI_LSB 4
`define STAT_PRIM_LSB 8
`define STAT_VAL_LSB  16

// switch counter width
`define SWITCH_CNT_W 16

// axi4-lite widths
`define AXI_ADDR_W   4
`define AXI_DATA_W   32

`endif

/* hw/hart_pkg.sv */
`default_nettype none

`include "hart_params.svh"

package hart_pkg;

    // one bit per hart, hart 0 lowest
    typedef logic [`HART_NUM-1:0]  hart_mask_t;
    typedef logic [`HART_ID_W-1:0] hart_id_t;

    // per hart state as seen in STATUS
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        ACTIVE = 2'd1,
        PEND   = 2'd2   // waiting on a cache fill
    } hart_val_t;

    // hart index to one-hot mask
    function automatic hart_mask_t hart_bit(input hart_id_t id);
        hart_bit = hart_mask_t'(1) << id;
    endfunction

endpackage

`default_nettype wire

/* hw/hart_pick.sv */
`default_nettype none

`include "hart_params.svh"

module hart_pick (
    input  wire hart_pkg::hart_mask_t i_acti_mask,
    input  wire hart_pkg::hart_mask_t i_cur_mask,
    output hart_pkg::hart_mask_t      o_next_mask
);
    import hart_pkg::*;

    localparam int N = `HART_NUM;

    hart_id_t       cur_id;
    hart_id_t       shift;     // search starts one above current primary
    hart_mask_t     cand;
    hart_mask_t     rot;
    hart_mask_t     pick;
    logic [2*N-1:0] cand_dbl;
    logic [2*N-1:0] back_dbl;

    // current primary as an index with an empty mask reading as 0
    always_comb begin
        cur_id = '0;
        for (int i = 0; i < N; i++) begin
            if (i_cur_mask[i]) cur_id = hart_id_t'(i);
        end
    end

    assign shift    = cur_id + hart_id_t'(1);
    assign cand     = i_acti_mask & ~i_cur_mask;   // old primary never chosen
    assign cand_dbl = {cand, cand};
    assign rot      = cand_dbl[shift +: N];
    assign pick     = rot & (~rot + hart_mask_t'(1)); // lowest set bit
    assign back_dbl = {pick, pick} << shift;

    assign o_next_mask = back_dbl[2*N-1:N];

    // one candidate hart after rotating back, and none only when no candidate exists
    always_comb begin
        assert ($onehot0(o_next_mask) && ((o_next_mask & ~cand) == '0) &&
                ((o_next_mask == '0) == (cand == '0)))
        else $error("hart_pick: choice %b does not fit candidates %b", o_next_mask, cand);
    end

endmodule

`default_nettype wire

/* hw/hart_state.sv */
`default_nettype none

`include "hart_params.svh"

module hart_state (
    input  wire                     clk,
    input  wire                     rst,

    // commands from the register block
    input  wire                     i_hstart,
    input  wire                     i_hkill,
    input  wire hart_pkg::hart_id_t i_hart_id,

    // cache events, one-cycle strobes
    input  wire                     i_if_miss,
    input  wire hart_pkg::hart_id_t i_if_hart,
    input  wire                     i_mem_miss,
    input  wire hart_pkg::hart_id_t i_mem_hart,
    input  wire                     i_if_fin,
    input  wire hart_pkg::hart_id_t i_if_fin_hart,
    input  wire                     i_mem_fin,
    input  wire hart_pkg::hart_id_t i_mem_fin_hart,

    output hart_pkg::hart_mask_t    o_idle_mask,
    output hart_pkg::hart_mask_t    o_acti_mask,
    output hart_pkg::hart_mask_t    o_prim_mask,
    output logic                    o_prim_switch
);
    import hart_pkg::*;

    hart_mask_t idle_q, acti_q, prim_q;
    hart_mask_t idle_nx, acti_nx, prim_nx;
    hart_mask_t pick_mask;
    hart_mask_t cmd_m;
    logic       start_ok;
    logic       kill_ok;
    logic       prim_lost;

    assign cmd_m    = hart_bit(i_hart_id);
    assign start_ok = i_hstart && idle_q[i_hart_id];   // only idle harts start
    assign kill_ok  = i_hkill && !idle_q[i_hart_id];   // killing idle is a no-op

    // fills first, then misses, then start or kill
    always_comb begin
        acti_nx = acti_q;
        if (i_if_fin)   acti_nx = acti_nx | (hart_bit(i_if_fin_hart) & ~idle_q);
        if (i_mem_fin)  acti_nx = acti_nx | (hart_bit(i_mem_fin_hart) & ~idle_q);
        if (i_if_miss)  acti_nx = acti_nx & ~hart_bit(i_if_hart);
        if (i_mem_miss) acti_nx = acti_nx & ~hart_bit(i_mem_hart);
        if (kill_ok)
            acti_nx = acti_nx & ~cmd_m;
        else if (start_ok)
            acti_nx = acti_nx | cmd_m;
    end

    always_comb begin
        idle_nx = idle_q;
        if (kill_ok)
            idle_nx = idle_nx | cmd_m;
        else if (start_ok)
            idle_nx = idle_nx & ~cmd_m;
    end

    // zero primary never matches a one-hot id
    assign prim_lost = (i_if_miss  && hart_bit(i_if_hart)  == prim_q) ||
                       (i_mem_miss && hart_bit(i_mem_hart) == prim_q) ||
                       (kill_ok    && cmd_m                == prim_q);

    hart_pick u_hart_pick (
        .i_acti_mask (acti_nx),
        .i_cur_mask  (prim_q),
        .o_next_mask (pick_mask)
    );

    always_comb begin
        prim_nx = prim_q;
        if (prim_q == '0) begin
            // reclaim by fill, fetch side first
            if (i_if_fin && !idle_nx[i_if_fin_hart])
                prim_nx = hart_bit(i_if_fin_hart);
            else if (i_mem_fin && !idle_nx[i_mem_fin_hart])
                prim_nx = hart_bit(i_mem_fin_hart);
        end else if (prim_lost) begin
            prim_nx = pick_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idle_q        <= ~hart_mask_t'(1);   // only hart 0 runs out of reset
            acti_q        <= hart_mask_t'(1);
            prim_q        <= hart_mask_t'(1);
            o_prim_switch <= 1'b0;
        end else begin
            idle_q        <= idle_nx;
            acti_q        <= acti_nx;
            prim_q        <= prim_nx;
            o_prim_switch <= (prim_nx != prim_q);
        end
    end

    assign o_idle_mask = idle_q;
    assign o_acti_mask = acti_q;
    assign o_prim_mask = prim_q;

    a_prim_onehot : assert property (@(posedge clk) disable iff (rst)
        $onehot0(prim_q))
    else $error("hart_state: primary mask %b not one-hot", prim_q);

    a_prim_not_idle : assert property (@(posedge clk) disable iff (rst)
        (prim_q & idle_q) == '0)
    else $error("hart_state: primary hart is idle");

    a_acti_idle_apart : assert property (@(posedge clk) disable iff (rst)
        (acti_q & idle_q) == '0)
    else $error("hart_state: active and idle masks overlap");

endmodule

`default_nettype wire

/* hw/hart_ctrl_regs.sv */
`default_nettype none

`include "hart_params.svh"

module hart_ctrl_regs (
    input  wire                         clk,
    input  wire                         rst,

    // axi4-lite slave
    input  wire                         i_awvalid,
    output logic                        o_awready,
    input  wire [`AXI_ADDR_W-1:0]       i_awaddr,
    input  wire                         i_wvalid,
    output logic                        o_wready,
    input  wire [`AXI_DATA_W-1:0]       i_wdata,
    input  wire [`AXI_DATA_W/8-1:0]     i_wstrb,
    output logic                        o_bvalid,
    input  wire                         i_bready,
    output logic [1:0]                  o_bresp,
    input  wire                         i_arvalid,
    output logic                        o_arready,
    input  wire [`AXI_ADDR_W-1:0]       i_araddr,
    output logic                        o_rvalid,
    input  wire                         i_rready,
    output logic [`AXI_DATA_W-1:0]      o_rdata,
    output logic [1:0]                  o_rresp,

    // commands to the hart state unit
    output logic                        o_hstart,
    output logic                        o_hkill,
    output hart_pkg::hart_id_t          o_hart_id,

    // hart state
    input  wire hart_pkg::hart_mask_t   i_idle_mask,
    input  wire hart_pkg::hart_mask_t   i_acti_mask,
    input  wire hart_pkg::hart_mask_t   i_prim_mask,
    input  wire                         i_prim_switch
);
    import hart_pkg::*;

    // write channel holding registers
    logic                     aw_held;
    logic [`AXI_ADDR_W-1:0]   aw_addr_q;
    logic                     w_held;
    logic [`AXI_DATA_W-1:0]   w_data_q;
    logic [`AXI_DATA_W/8-1:0] w_strb_q;

    logic                     aw_fire, w_fire, ar_fire;
    logic                     wr_go;
    logic [`AXI_ADDR_W-1:0]   wr_addr;
    logic [`AXI_DATA_W-1:0]   wr_data;
    logic [`AXI_DATA_W/8-1:0] wr_strb;
    logic                     ctrl_cmd;

    logic [`SWITCH_CNT_W-1:0] sw_cnt;
    logic [`AXI_DATA_W-1:0]   status_word;
    logic [`AXI_DATA_W-1:0]   rd_word;
    hart_val_t                hval;

    assign o_awready = !aw_held && !o_bvalid;   // stall while response pending
    assign o_wready  = !w_held && !o_bvalid;
    assign o_arready = !o_rvalid;
    assign o_bresp   = 2'b00;
    assign o_rresp   = 2'b00;

    assign aw_fire = i_awvalid && o_awready;
    assign w_fire  = i_wvalid && o_wready;
    assign ar_fire = i_arvalid && o_arready;

    // perform once both halves are held or arriving now
    assign wr_go   = (aw_held || aw_fire) && (w_held || w_fire);
    assign wr_addr = aw_held ? aw_addr_q : i_awaddr;
    assign wr_data = w_held ? w_data_q : i_wdata;
    assign wr_strb = w_held ? w_strb_q : i_wstrb;

    // command bits live in byte 1
    assign ctrl_cmd = wr_go && (wr_addr == `REG_CTRL) && wr_strb[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
            o_bvalid <= 1'b0;
            o_hstart <= 1'b0;
            o_hkill  <= 1'b0;
        end else begin
            if (wr_go)
                aw_held <= 1'b0;
            else if (aw_fire)
                aw_held <= 1'b1;
            if (wr_go)
                w_held <= 1'b0;
            else if (w_fire)
                w_held <= 1'b1;
            if (wr_go)
                o_bvalid <= 1'b1;
            else if (i_bready)
                o_bvalid <= 1'b0;
            // kill wins over start
            o_hkill  <= ctrl_cmd && wr_data[`CTRL_KILL_BIT];
            o_hstart <= ctrl_cmd && wr_data[`CTRL_START_BIT] && !wr_data[`CTRL_KILL_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) aw_addr_q <= i_awaddr;
        if (w_fire) begin
            w_data_q <= i_wdata;
            w_strb_q <= i_wstrb;
        end
        if (ctrl_cmd) o_hart_id <= hart_id_t'(wr_data[`HART_ID_W-1:0]);
    end

    // saturating switch counter that any write clears
    always_ff @(posedge clk) begin
        if (rst)
            sw_cnt <= '0;
        else if (wr_go && wr_addr == `REG_SWITCHES)
            sw_cnt <= '0;
        else if (i_prim_switch && sw_cnt != '1)
            sw_cnt <= sw_cnt + 1'b1;   // saturates
    end

    always_comb begin
        status_word = '0;
        status_word[`STAT_IDLE_LSB +: `HART_NUM] = i_idle_mask;
        status_word[`STAT_ACTI_LSB +: `HART_NUM] = i_acti_mask;
        status_word[`STAT_PRIM_LSB +: `HART_NUM] = i_prim_mask;
        for (int i = 0; i < `HART_NUM; i++) begin
            if (i_idle_mask[i])
                hval = IDLE;
            else if (i_acti_mask[i])
                hval = ACTIVE;
            else
                hval = PEND;   // stalled on a fill
            status_word[`STAT_VAL_LSB + 2*i +: 2] = hval;
        end
    end

    always_comb begin
        case (i_araddr)
            `REG_STATUS:   rd_word = status_word;
            `REG_SWITCHES: rd_word = {{(`AXI_DATA_W-`SWITCH_CNT_W){1'b0}}, sw_cnt};
            default:       rd_word = '0;   // CTRL is write only
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            o_rvalid <= 1'b0;
        else if (ar_fire)
            o_rvalid <= 1'b1;
        else if (i_rready)
            o_rvalid <= 1'b0;
    end

    // data stays put while RREADY is low
    always_ff @(posedge clk) begin
        if (ar_fire) o_rdata <= rd_word;
    end

    a_no_start_kill : assert property (@(posedge clk) disable iff (rst)
        !(o_hstart && o_hkill))
    else $error("hart_ctrl_regs: start and kill pulsed together");

    // the pending response blocks the next write, so pulses never run back to back
    a_cmd_one_cycle : assert property (@(posedge clk) disable iff (rst)
        (o_hstart || o_hkill) |=> !(o_hstart || o_hkill))
    else $error("hart_ctrl_regs: command pulse lasted more than one cycle");

endmodule

`default_nettype wire

/* hw/hart_sched_top.sv */
`default_nettype none

`include "hart_params.svh"

module hart_sched_top (
    input  wire                     clk,
    input  wire                     rst,

    // axi4-lite slave
    input  wire                     i_awvalid,
    output logic                    o_awready,
    input  wire [`AXI_ADDR_W-1:0]   i_awaddr,
    input  wire                     i_wvalid,
    output logic                    o_wready,
    input  wire [`AXI_DATA_W-1:0]   i_wdata,
    input  wire [`AXI_DATA_W/8-1:0] i_wstrb,
    output logic                    o_bvalid,
    input  wire                     i_bready,
    output logic [1:0]              o_bresp,
    input  wire                     i_arvalid,
    output logic                    o_arready,
    input  wire [`AXI_ADDR_W-1:0]   i_araddr,
    output logic                    o_rvalid,
    input  wire                     i_rready,
    output logic [`AXI_DATA_W-1:0]  o_rdata,
    output logic [1:0]              o_rresp,

    // cache events
    input  wire                     i_if_miss,
    input  wire hart_pkg::hart_id_t i_if_hart,
    input  wire                     i_mem_miss,
    input  wire hart_pkg::hart_id_t i_mem_hart,
    input  wire                     i_if_fin,
    input  wire hart_pkg::hart_id_t i_if_fin_hart,
    input  wire                     i_mem_fin,
    input  wire hart_pkg::hart_id_t i_mem_fin_hart
);
    import hart_pkg::*;

    logic       hstart, hkill, prim_switch;
    hart_id_t   hart_id;
    hart_mask_t idle_mask, acti_mask, prim_mask;

    hart_ctrl_regs u_hart_ctrl_regs (
        .clk           (clk),
        .rst           (rst),
        .i_awvalid     (i_awvalid),
        .o_awready     (o_awready),
        .i_awaddr      (i_awaddr),
        .i_wvalid      (i_wvalid),
        .o_wready      (o_wready),
        .i_wdata       (i_wdata),
        .i_wstrb       (i_wstrb),
        .o_bvalid      (o_bvalid),
        .i_bready      (i_bready),
        .o_bresp       (o_bresp),
        .i_arvalid     (i_arvalid),
        .o_arready     (o_arready),
        .i_araddr      (i_araddr),
        .o_rvalid      (o_rvalid),
        .i_rready      (i_rready),
        .o_rdata       (o_rdata),
        .o_rresp       (o_rresp),
        .o_hstart      (hstart),
        .o_hkill       (hkill),
        .o_hart_id     (hart_id),
        .i_idle_mask   (idle_mask),
        .i_acti_mask   (acti_mask),
        .i_prim_mask   (prim_mask),
        .i_prim_switch (prim_switch)
    );

    hart_state u_hart_state (
        .clk            (clk),
        .rst            (rst),
        .i_hstart       (hstart),
        .i_hkill        (hkill),
        .i_hart_id      (hart_id),
        .i_if_miss      (i_if_miss),
        .i_if_hart      (i_if_hart),
        .i_mem_miss     (i_mem_miss),
        .i_mem_hart     (i_mem_hart),
        .i_if_fin       (i_if_fin),
        .i_if_fin_hart  (i_if_fin_hart),
        .i_mem_fin      (i_mem_fin),
        .i_mem_fin_hart (i_mem_fin_hart),
        .o_idle_mask    (idle_mask),
        .o_acti_mask    (acti_mask),
        .o_prim_mask    (prim_mask),
        .o_prim_switch  (prim_switch)
    );

endmodule

`default_nettype wire

/* testbench/tb_hart_sched_table.svh */
`ifndef TB_HART_SCHED_TABLE_SVH
`define TB_HART_SCHED_TABLE_SVH

// columns: op, hart, second hart (dual fill only), then the expected
// idle, active and primary masks and the SWITCHES count after the op
task automatic load_directed_rows();
    // state straight out of reset
    rows.push_back(make_row(OP_READ,      2'd0, 2'd0, 4'b1110, 4'b0001, 4'b0001, 16'd0));

    // bring up harts 2 and 1
    rows.push_back(make_row(OP_START,     2'd2, 2'd0, 4'b1010, 4'b0101, 4'b0001, 16'd0));
    rows.push_back(make_row(OP_START,     2'd1, 2'd0, 4'b1000, 4'b0111, 4'b0001, 16'd0));
    // already running, no effect
    rows.push_back(make_row(OP_START,     2'd2, 2'd0, 4'b1000, 4'b0111, 4'b0001, 16'd0));
    // idle hart, kill ignored and the start bit loses
    rows.push_back(make_row(OP_KILL,      2'd3, 2'd0, 4'b1000, 4'b0111, 4'b0001, 16'd0));

    // primary walks upward on misses, hart 0 now pending
    rows.push_back(make_row(OP_IF_MISS,   2'd0, 2'd0, 4'b1000, 4'b0110, 4'b0010, 16'd1));
    rows.push_back(make_row(OP_MEM_MISS,  2'd1, 2'd0, 4'b1000, 4'b0100, 4'b0100, 16'd2));

    // nobody left to run
    rows.push_back(make_row(OP_IF_MISS,   2'd2, 2'd0, 4'b1000, 4'b0000, 4'b0000, 16'd3));

    // fetch fill on hart 1, memory fill on hart 0, fetch side takes primary
    rows.push_back(make_row(OP_DUAL_FILL, 2'd1, 2'd0, 4'b1000, 4'b0011, 4'b0010, 16'd4));

    // kill the primary, wraps around to hart 0
    rows.push_back(make_row(OP_KILL,      2'd1, 2'd0, 4'b1010, 4'b0001, 4'b0001, 16'd5));
    rows.push_back(make_row(OP_CLR_SW,    2'd0, 2'd0, 4'b1010, 4'b0001, 4'b0001, 16'd0));

    // fill of a pending hart vs fill of an idle one
    rows.push_back(make_row(OP_IF_FILL,   2'd2, 2'd0, 4'b1010, 4'b0101, 4'b0001, 16'd0));
    rows.push_back(make_row(OP_MEM_FILL,  2'd3, 2'd0, 4'b1010, 4'b0101, 4'b0001, 16'd0));

    rows.push_back(make_row(OP_START,     2'd3, 2'd0, 4'b0010, 4'b1101, 4'b0001, 16'd0));
endtask

`endif

/* testbench/tb_hart_sched.sv */
`default_nettype none

`include "hart_params.svh"

module tb_hart_sched;
    import hart_pkg::*;

    localparam int TIMEOUT = 50;   // cycles allowed per handshake wait

    typedef enum logic [3:0] {
        OP_READ, OP_START, OP_KILL, OP_IF_MISS, OP_MEM_MISS,
        OP_IF_FILL, OP_MEM_FILL, OP_DUAL_FILL, OP_CLR_SW
    } op_t;

    typedef struct packed {
        op_t         op;
        hart_id_t    h0;
        hart_id_t    h1;     // memory side hart of a dual fill
        hart_mask_t  idle;
        hart_mask_t  acti;
        hart_mask_t  prim;
        logic [15:0] sw;
    } row_t;

    logic                     clk;
    logic                     rst;
    logic                     awvalid, wvalid, bready, arvalid, rready;
    logic                     awready, wready, bvalid, arready, rvalid;
    logic [`AXI_ADDR_W-1:0]   awaddr, araddr;
    logic [`AXI_DATA_W-1:0]   wdata, rdata;
    logic [`AXI_DATA_W/8-1:0] wstrb;
    logic [1:0]               bresp, rresp;
    logic                     if_miss, mem_miss, if_fin, mem_fin;
    hart_id_t                 if_hart, mem_hart, if_fin_hart, mem_fin_hart;

    row_t                     rows[$];
    int                       errors;
    logic [7:0]               lfsr;
    logic [`AXI_DATA_W-1:0]   rd;
    hart_mask_t               m_idle, m_acti, m_prim;   // reference model
    logic [15:0]              m_sw;

    hart_sched_top i_hart_sched_top (
        .clk (clk), .rst (rst),
        .i_awvalid (awvalid), .o_awready (awready), .i_awaddr (awaddr),
        .i_wvalid (wvalid), .o_wready (wready), .i_wdata (wdata), .i_wstrb (wstrb),
        .o_bvalid (bvalid), .i_bready (bready), .o_bresp (bresp),
        .i_arvalid (arvalid), .o_arready (arready), .i_araddr (araddr),
        .o_rvalid (rvalid), .i_rready (rready), .o_rdata (rdata), .o_rresp (rresp),
        .i_if_miss (if_miss), .i_if_hart (if_hart),
        .i_mem_miss (mem_miss), .i_mem_hart (mem_hart),
        .i_if_fin (if_fin), .i_if_fin_hart (if_fin_hart),
        .i_mem_fin (mem_fin), .i_mem_fin_hart (mem_fin_hart)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic row_t make_row(input op_t op, input hart_id_t h0, input hart_id_t h1,
                                      input hart_mask_t idle, input hart_mask_t acti,
                                      input hart_mask_t prim, input logic [15:0] sw);
        make_row = '{op, h0, h1, idle, acti, prim, sw};
    endfunction

    `include "tb_hart_sched_table.svh"

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        lfsr_next = {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // STATUS word as the register map lays it out
    function automatic logic [31:0] expected_status(input hart_mask_t idle,
                                                    input hart_mask_t acti,
                                                    input hart_mask_t prim);
        logic [31:0] w;
        w = '0;
        w[3:0]  = idle;
        w[7:4]  = acti;
        w[11:8] = prim;
        for (int i = 0; i < `HART_NUM; i++) begin
            if (idle[i])
                w[16 + 2*i +: 2] = IDLE;
            else if (acti[i])
                w[16 + 2*i +: 2] = ACTIVE;
            else
                w[16 + 2*i +: 2] = PEND;
        end
        return w;
    endfunction

    task automatic model_step(input op_t op, input hart_id_t h);
        hart_mask_t old_prim;
        logic       lost;
        int         p;
        int         idx;
        old_prim = m_prim;
        lost = 1'b0;
        p = 0;
        case (op)
            OP_START: if (m_idle[h]) begin
                m_idle[h] = 1'b0;
                m_acti[h] = 1'b1;
            end
            OP_KILL: if (!m_idle[h]) begin
                m_idle[h] = 1'b1;
                m_acti[h] = 1'b0;
                lost = m_prim[h];
            end
            OP_IF_MISS, OP_MEM_MISS: begin
                m_acti[h] = 1'b0;
                lost = m_prim[h];
            end
            OP_IF_FILL, OP_MEM_FILL: if (!m_idle[h]) begin
                m_acti[h] = 1'b1;
                if (m_prim == '0)
                    m_prim[h] = 1'b1;   // reclaim a parked core
            end
            default: ;
        endcase
        if (lost) begin
            for (int i = 0; i < `HART_NUM; i++)
                if (old_prim[i]) p = i;
            m_prim = '0;
            // walk downward so the nearest hart above the old one is kept
            for (int k = `HART_NUM - 1; k >= 1; k--) begin
                idx = (p + k) % `HART_NUM;
                if (m_acti[idx]) begin
                    m_prim = '0;
                    m_prim[idx] = 1'b1;
                end
            end
        end
        if (m_prim != old_prim)
            m_sw = m_sw + 16'd1;
    endtask

    task automatic add_random_rows(input int n);
        op_t      op;
        hart_id_t h;
        for (int i = 0; i < n; i++) begin
            case (take_bits(3) % 6)
                0:       op = OP_START;
                1:       op = OP_KILL;
                2:       op = OP_IF_MISS;
                3:       op = OP_MEM_MISS;
                4:       op = OP_IF_FILL;
                default: op = OP_MEM_FILL;
            endcase
            h = hart_id_t'(take_bits(2));
            model_step(op, h);
            rows.push_back(make_row(op, h, h, m_idle, m_acti, m_prim, m_sw));
        end
    endtask

    task automatic axi_write(input logic [`AXI_ADDR_W-1:0] addr,
                             input logic [`AXI_DATA_W-1:0] data);
        int   t;
        logic aw_done;
        logic w_done;
        logic b_done;
        aw_done = 1'b0;
        w_done = 1'b0;
        b_done = 1'b0;
        t = 0;
        @(posedge clk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        wstrb   <= '1;
        while (!(aw_done && w_done) && t < TIMEOUT) begin
            @(posedge clk);
            t++;
            if (awvalid && awready) begin
                aw_done = 1'b1;
                awvalid <= 1'b0;
            end
            if (wvalid && wready) begin
                w_done = 1'b1;
                wvalid <= 1'b0;
            end
        end
        if (!(aw_done && w_done)) begin
            $display("timeout: write address or data was never accepted at %0t", $time);
            errors++;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end
        bready <= 1'b1;
        t = 0;
        while (!b_done && t < TIMEOUT) begin
            @(posedge clk);
            t++;
            if (bvalid && bready) begin
                b_done = 1'b1;
                check_value("BRESP", 32'(bresp), 32'd0);
            end
        end
        bready <= 1'b0;
        if (!b_done) begin
            $display("timeout: no write response at %0t", $time);
            errors++;
        end
    endtask

    // stall holds RREADY low for that many cycles once data is valid
    task automatic axi_read(input logic [`AXI_ADDR_W-1:0] addr, input int stall,
                            output logic [`AXI_DATA_W-1:0] data);
        int   t;
        logic done;
        t = 0;
        done = 1'b0;
        data = '0;
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        while (!done && t < TIMEOUT) begin
            @(posedge clk);
            t++;
            if (arready) done = 1'b1;
        end
        arvalid <= 1'b0;
        if (!done) begin
            $display("timeout: read address was never accepted at %0t", $time);
            errors++;
        end
        t = 0;
        while (!rvalid && t < TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        if (!rvalid) begin
            $display("timeout: read data never became valid at %0t", $time);
            errors++;
        end
        data = rdata;
        repeat (stall) begin
            @(posedge clk);
            check_value("RVALID while stalled", 32'(rvalid), 32'd1);
            check_value("RDATA while stalled", rdata, data);
        end
        rready <= 1'b1;
        t = 0;
        done = 1'b0;
        while (!done && t < TIMEOUT) begin
            @(posedge clk);
            t++;
            if (rvalid) begin
                done = 1'b1;
                check_value("RDATA at handshake", rdata, data);
                check_value("RRESP", 32'(rresp), 32'd0);
            end
        end
        rready <= 1'b0;
        if (!done) begin
            $display("timeout: read data never arrived at %0t", $time);
            errors++;
        end
    endtask

    task automatic pulse_event(input op_t op, input hart_id_t h0, input hart_id_t h1);
        @(posedge clk);
        if_miss      <= (op == OP_IF_MISS);
        mem_miss     <= (op == OP_MEM_MISS);
        if_fin       <= (op == OP_IF_FILL) || (op == OP_DUAL_FILL);
        mem_fin      <= (op == OP_MEM_FILL) || (op == OP_DUAL_FILL);
        if_hart      <= h0;
        mem_hart     <= h0;
        if_fin_hart  <= h0;
        mem_fin_hart <= (op == OP_DUAL_FILL) ? h1 : h0;
        @(posedge clk);
        if_miss  <= 1'b0;
        mem_miss <= 1'b0;
        if_fin   <= 1'b0;
        mem_fin  <= 1'b0;
    endtask

    task automatic apply_op(input row_t r);
        case (r.op)
            OP_START:  axi_write(`REG_CTRL, 32'h100 | 32'(r.h0));
            OP_KILL:   axi_write(`REG_CTRL, 32'h300 | 32'(r.h0));   // kill must beat the start bit
            OP_CLR_SW: axi_write(`REG_SWITCHES, 32'h0000_5a5a);
            OP_READ:   ;
            default:   pulse_event(r.op, r.h0, r.h1);
        endcase
    endtask

    initial begin
        rst          <= 1'b1;
        awvalid      <= 1'b0;
        awaddr       <= '0;
        wvalid       <= 1'b0;
        wdata        <= '0;
        wstrb        <= '0;
        bready       <= 1'b0;
        arvalid      <= 1'b0;
        araddr       <= '0;
        rready       <= 1'b0;
        if_miss      <= 1'b0;
        mem_miss     <= 1'b0;
        if_fin       <= 1'b0;
        mem_fin      <= 1'b0;
        if_hart      <= '0;
        mem_hart     <= '0;
        if_fin_hart  <= '0;
        mem_fin_hart <= '0;
        errors = 0;
        lfsr = 8'd28;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("BVALID after reset", 32'(bvalid), 32'd0);
        check_value("RVALID after reset", 32'(rvalid), 32'd0);

        load_directed_rows();
        // random rows continue from where the directed ones leave off
        m_idle = rows[rows.size()-1].idle;
        m_acti = rows[rows.size()-1].acti;
        m_prim = rows[rows.size()-1].prim;
        m_sw   = rows[rows.size()-1].sw;
        add_random_rows(24);

        foreach (rows[i]) begin
            apply_op(rows[i]);
            repeat (3) @(posedge clk);   // pulse, mask update, switch count
            axi_read(`REG_STATUS, (i % 4 == 3) ? 3 : 0, rd);
            check_value($sformatf("row %0d STATUS", i), rd,
                        expected_status(rows[i].idle, rows[i].acti, rows[i].prim));
            axi_read(`REG_SWITCHES, 0, rd);
            check_value($sformatf("row %0d SWITCHES", i), rd, {16'd0, rows[i].sw});
        end

        $display("rows run: %0d, errors: %0d", rows.size(), errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
+incdir+testbench
hw/hart_pkg.sv
hw/hart_pick.sv
hw/hart_state.sv
hw/hart_ctrl_regs.sv
hw/hart_sched_top.sv
testbench/tb_hart_sched.sv

/* Makefile */
SRCS = $(wildcard hw/*.sv include/*.svh testbench/*.sv testbench/*.svh) sim.f

.PHONY: all run lint clean

all: run

obj_dir/Vtb_hart_sched: $(SRCS)
	verilator --binary --timing --assert -f sim.f --top-module tb_hart_sched \
		-o Vtb_hart_sched

run: obj_dir/Vtb_hart_sched
	./obj_dir/Vtb_hart_sched > sim.log 2>&1; cat sim.log
	grep -qx "test passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module hart_sched_top

clean:
	rm -rf obj_dir sim.log
